// File: qspi_pattern_flash_params.svh
`ifndef QSPI_PATTERN_FLASH_PARAMS_SVH
`define QSPI_PATTERN_FLASH_PARAMS_SVH

// Number of reply entries held between the decoder and the serializer
`define QSPI_FIFO_DEPTH 8

// Manufacturer, memory type and capacity, sent in this order
`define QSPI_CHIP_ID 24'h1F8501

// Dummy bytes that follow the mode byte of a quad read
`define QSPI_DUMMY_BYTES 2

`endif

// File: qspi_cmd_pkg.sv
package qspi_cmd_pkg;

    // Opcodes recognised in the first byte after chip select
    typedef enum logic [7:0] {
        CMD_READ_ID   = 8'h9F,
        CMD_QUAD_READ = 8'hEB
    } cmd_code_e;

    // Command phase tracking in the decoder
    typedef enum logic [3:0] {
        IDLE,
        ADDR_1,
        ADDR_2,
        ADDR_3,
        MODE,
        DUMMY,
        SEND_QUAD,
        SEND_ID,
        IGNORE
    } decoder_state_e;

endpackage

// File: qspi_data_pkg.sv
package qspi_data_pkg;

    typedef logic [7:0]  flash_byte_t;
    typedef logic [23:0] flash_addr_t;
    typedef logic [3:0]  flash_nibble_t;

    // One command, address, mode or dummy byte from the host
    typedef struct packed {
        flash_byte_t data;
    } host_lane_t;

    // Reply byte plus the way it leaves the chip
    typedef struct packed {
        logic        quad;
        flash_byte_t data;
    } reply_entry_t;

    // In single-bit transfers only bit 1 carries data, as on the so pin
    typedef struct packed {
        logic          quad;
        flash_nibble_t nibble;
    } out_lane_t;

endpackage

// File: qspi_command_decoder.sv
`timescale 1ns/1ps
`include "qspi_pattern_flash_params.svh"

module qspi_command_decoder (
    input  logic                        recv_got_byte,
    input  logic                        cs,
    input  logic                        host_req,
    input  qspi_data_pkg::host_lane_t   host_lane,
    output logic                        host_ack,
    input  logic                        reply_full,
    output logic                        reply_push,
    output qspi_data_pkg::reply_entry_t reply_entry
);

    localparam int DUMMY_W = $clog2(`QSPI_DUMMY_BYTES + 1);
    localparam logic [23:0] CHIP_ID = `QSPI_CHIP_ID;

    qspi_cmd_pkg::decoder_state_e state;
    qspi_data_pkg::flash_addr_t   addr;
    qspi_data_pkg::flash_byte_t   addr_xor;
    qspi_data_pkg::flash_byte_t   id_byte;
    logic [1:0]                   id_pos;
    logic [DUMMY_W-1:0]           dummy_cnt;
    logic                         byte_in;
    logic                         last_dummy;

    // A host byte is taken in the cycle that raises host_ack
    assign byte_in = host_req && !host_ack;
    assign last_dummy = dummy_cnt == DUMMY_W'(`QSPI_DUMMY_BYTES - 1);

    assign addr_xor = addr[23:16] ^ addr[15:8] ^ addr[7:0];

    always_comb begin
        case (id_pos)
            2'd0:    id_byte = CHIP_ID[23:16];
            2'd1:    id_byte = CHIP_ID[15:8];
            default: id_byte = CHIP_ID[7:0];
        endcase
    end

    assign reply_push = (state == qspi_cmd_pkg::SEND_QUAD || state == qspi_cmd_pkg::SEND_ID)
                        && !reply_full;
    assign reply_entry.quad = state == qspi_cmd_pkg::SEND_QUAD;
    assign reply_entry.data = (state == qspi_cmd_pkg::SEND_QUAD) ? addr_xor : id_byte;

    always_ff @(posedge recv_got_byte or posedge cs) begin
        if (cs) begin
            state    <= qspi_cmd_pkg::IDLE;
            host_ack <= 1'b0;
        end else begin
            host_ack <= host_req;
            if (byte_in) begin
                case (state)
                    qspi_cmd_pkg::IDLE: begin
                        if (host_lane.data == qspi_cmd_pkg::CMD_READ_ID) begin
                            state <= qspi_cmd_pkg::SEND_ID;
                        end else if (host_lane.data == qspi_cmd_pkg::CMD_QUAD_READ) begin
                            state <= qspi_cmd_pkg::ADDR_1;
                        end else begin
                            state <= qspi_cmd_pkg::IGNORE;
                        end
                    end
                    qspi_cmd_pkg::ADDR_1: state <= qspi_cmd_pkg::ADDR_2;
                    qspi_cmd_pkg::ADDR_2: state <= qspi_cmd_pkg::ADDR_3;
                    qspi_cmd_pkg::ADDR_3: state <= qspi_cmd_pkg::MODE;
                    qspi_cmd_pkg::MODE:   state <= qspi_cmd_pkg::DUMMY;
                    qspi_cmd_pkg::DUMMY: begin
                        if (last_dummy) begin
                            state <= qspi_cmd_pkg::SEND_QUAD;
                        end
                    end
                    // Bytes in the reply phase are acknowledged and dropped
                    default: state <= state;
                endcase
            end
        end
    end

    // Address bytes shift in, then the address or identifier position steps with each push
    always_ff @(posedge recv_got_byte) begin
        if (byte_in && state == qspi_cmd_pkg::IDLE) begin
            id_pos <= 2'd0;
        end else if (state == qspi_cmd_pkg::SEND_ID && reply_push) begin
            id_pos <= (id_pos == 2'd2) ? 2'd0 : id_pos + 2'd1;
        end

        if (byte_in && state == qspi_cmd_pkg::MODE) begin
            dummy_cnt <= '0;
        end else if (byte_in && state == qspi_cmd_pkg::DUMMY) begin
            dummy_cnt <= dummy_cnt + 1'b1;
        end

        if (byte_in && (state == qspi_cmd_pkg::ADDR_1 || state == qspi_cmd_pkg::ADDR_2 ||
                        state == qspi_cmd_pkg::ADDR_3)) begin
            addr <= {addr[15:0], host_lane.data};
        end else if (state == qspi_cmd_pkg::SEND_QUAD && reply_push) begin
            addr <= addr + 1'b1;
        end
    end

endmodule

// File: qspi_reply_fifo.sv
`timescale 1ns/1ps
`include "qspi_pattern_flash_params.svh"

module qspi_reply_fifo #(
    parameter int DEPTH = `QSPI_FIFO_DEPTH
) (
    input  logic                        recv_got_byte,
    input  logic                        cs,
    input  logic                        push,
    input  qspi_data_pkg::reply_entry_t push_entry,
    output logic                        full,
    input  logic                        pop,
    output qspi_data_pkg::reply_entry_t head,
    output logic                        empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    qspi_data_pkg::reply_entry_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full  = count == CNT_W'(DEPTH);
    assign empty = count == '0;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head = mem[rd_ptr];

    always_ff @(posedge recv_got_byte or posedge cs) begin
        if (cs) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge recv_got_byte) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

endmodule

// File: qspi_nibble_serializer.sv
`timescale 1ns/1ps

module qspi_nibble_serializer (
    input  logic                        recv_got_byte,
    input  logic                        cs,
    input  logic                        fifo_empty,
    input  qspi_data_pkg::reply_entry_t fifo_head,
    output logic                        fifo_pop,
    output logic                        out_req,
    input  logic                        out_ack,
    output qspi_data_pkg::out_lane_t    out_lane
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_ACK_LOW
    } ser_state_e;

    ser_state_e                 state;
    qspi_data_pkg::flash_byte_t shift;
    logic                       quad;
    logic [3:0]                 remaining;

    // An entry is taken only when nothing is in flight
    assign fifo_pop = state == S_IDLE && !fifo_empty;
    assign out_req  = state == S_REQ;

    // Most significant data first, single bits go out on bit 1
    assign out_lane.quad   = quad;
    assign out_lane.nibble = quad ? shift[7:4] : {2'b00, shift[7], 1'b0};

    always_ff @(posedge recv_got_byte or posedge cs) begin
        if (cs) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (fifo_pop) begin
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (out_ack) begin
                        state <= S_ACK_LOW;
                    end
                end
                S_ACK_LOW: begin
                    if (!out_ack) begin
                        state <= (remaining != 4'd0) ? S_REQ : S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge recv_got_byte) begin
        if (fifo_pop) begin
            shift     <= fifo_head.data;
            quad      <= fifo_head.quad;
            remaining <= fifo_head.quad ? 4'd2 : 4'd8;
        end else if (state == S_REQ && out_ack) begin
            shift     <= quad ? {shift[3:0], 4'b0000} : {shift[6:0], 1'b0};
            remaining <= remaining - 4'd1;
        end
    end

endmodule

// File: qspi_pattern_flash.sv
`timescale 1ns/1ps

module qspi_pattern_flash (
    input  logic                      recv_got_byte,
    input  logic                      cs,
    input  logic                      host_req,
    input  qspi_data_pkg::host_lane_t host_lane,
    output logic                      host_ack,
    output logic                      out_req,
    input  logic                      out_ack,
    output qspi_data_pkg::out_lane_t  out_lane
);

    logic                        reply_push;
    logic                        reply_full;
    qspi_data_pkg::reply_entry_t reply_entry;
    logic                        fifo_pop;
    logic                        fifo_empty;
    qspi_data_pkg::reply_entry_t fifo_head;

    qspi_command_decoder decoder_i (
        .recv_got_byte (recv_got_byte),
        .cs            (cs),
        .host_req      (host_req),
        .host_lane     (host_lane),
        .host_ack      (host_ack),
        .reply_full    (reply_full),
        .reply_push    (reply_push),
        .reply_entry   (reply_entry)
    );

    qspi_reply_fifo fifo_i (
        .recv_got_byte (recv_got_byte),
        .cs            (cs),
        .push          (reply_push),
        .push_entry    (reply_entry),
        .full          (reply_full),
        .pop           (fifo_pop),
        .head          (fifo_head),
        .empty         (fifo_empty)
    );

    qspi_nibble_serializer serializer_i (
        .recv_got_byte (recv_got_byte),
        .cs            (cs),
        .fifo_empty    (fifo_empty),
        .fifo_head     (fifo_head),
        .fifo_pop      (fifo_pop),
        .out_req       (out_req),
        .out_ack       (out_ack),
        .out_lane      (out_lane)
    );

endmodule

// File: qspi_pattern_flash_assertions.sv
`timescale 1ns/1ps

module qspi_pattern_flash_assertions (
    input logic                     recv_got_byte,
    input logic                     cs,
    input logic                     host_req,
    input logic                     host_ack,
    input logic                     out_req,
    input logic                     out_ack,
    input qspi_data_pkg::out_lane_t out_lane
);

    // Both request/acknowledge outputs sit low while chip select holds reset
    reset_outputs_low: assert property (
        @(posedge recv_got_byte) cs |-> (!host_ack && !out_req)
    ) else $error("host_ack or out_req high during reset");

    // The decoder answers a new host request on the following edge
    host_ack_follows_req: assert property (
        @(posedge recv_got_byte) disable iff (cs)
        (host_req && !host_ack) |=> host_ack
    ) else $error("host_ack did not rise one cycle after host_req");

    // Once requested, the output lane holds until the receiver acknowledges
    out_lane_stable: assert property (
        @(posedge recv_got_byte) disable iff (cs)
        (out_req && $past(out_req)) |-> $stable(out_lane)
    ) else $error("out_lane changed while out_req was pending");

    // A request is only withdrawn after it was acknowledged
    out_req_held_until_ack: assert property (
        @(posedge recv_got_byte) disable iff (cs)
        $fell(out_req) |-> $past(out_ack)
    ) else $error("out_req fell before out_ack rose");

    // No new transfer starts until the receiver has released its acknowledge
    out_req_waits_ack_low: assert property (
        @(posedge recv_got_byte) disable iff (cs)
        $rose(out_req) |-> !$past(out_ack)
    ) else $error("out_req rose while out_ack was still high");

endmodule

// File: qspi_pattern_flash_tb.sv
`timescale 1ns/1ps

module qspi_pattern_flash_tb;

    localparam int TIMEOUT = 2000;

    logic                      recv_got_byte;
    logic                      cs;
    logic                      host_req;
    qspi_data_pkg::host_lane_t host_lane;
    logic                      host_ack;
    logic                      out_req;
    logic                      out_ack;
    qspi_data_pkg::out_lane_t  out_lane;

    qspi_data_pkg::flash_byte_t chip_id [3] = '{8'h1F, 8'h85, 8'h01};

    qspi_pattern_flash dut_i (
        .recv_got_byte (recv_got_byte),
        .cs            (cs),
        .host_req      (host_req),
        .host_lane     (host_lane),
        .host_ack      (host_ack),
        .out_req       (out_req),
        .out_ack       (out_ack),
        .out_lane      (out_lane)
    );

    bind qspi_pattern_flash qspi_pattern_flash_assertions assertions_i (.*);

    initial begin
        recv_got_byte = 1'b0;
        forever #5 recv_got_byte = ~recv_got_byte;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic apply_reset();
        @(negedge recv_got_byte);
        cs = 1'b1;
        repeat (2) @(negedge recv_got_byte);
        cs = 1'b0;
    endtask

    task automatic send_host_byte(input qspi_data_pkg::flash_byte_t b);
        int n;
        @(negedge recv_got_byte);
        host_lane.data = b;
        host_req = 1'b1;
        n = 0;
        do begin
            @(negedge recv_got_byte);
            n++;
            if (n > TIMEOUT) stop_with_failure("Timed out waiting for host_ack to rise");
        end while (!host_ack);
        host_req = 1'b0;
        n = 0;
        while (host_ack) begin
            @(negedge recv_got_byte);
            n++;
            if (n > TIMEOUT) stop_with_failure("Timed out waiting for host_ack to fall");
        end
    endtask

    // Takes one output transfer, holding out_ack for a random number of cycles first
    task automatic take_transfer(input int max_delay, output qspi_data_pkg::out_lane_t lane);
        int n;
        n = 0;
        while (!out_req) begin
            @(negedge recv_got_byte);
            n++;
            if (n > TIMEOUT) stop_with_failure("Timed out waiting for out_req to rise");
        end
        lane = out_lane;
        repeat ($urandom_range(max_delay, 0)) @(negedge recv_got_byte);
        out_ack = 1'b1;
        n = 0;
        do begin
            @(negedge recv_got_byte);
            n++;
            if (n > TIMEOUT) stop_with_failure("Timed out waiting for out_req to fall");
        end while (out_req);
        out_ack = 1'b0;
    endtask

    task automatic receive_and_check(input logic quad, input qspi_data_pkg::flash_byte_t exp,
                                     input int max_delay);
        qspi_data_pkg::out_lane_t   lane;
        qspi_data_pkg::flash_byte_t got;
        int                         count;
        got = '0;
        count = quad ? 2 : 8;
        for (int i = 0; i < count; i++) begin
            take_transfer(max_delay, lane);
            if (lane.quad !== quad) begin
                $display("error: time %0t quad flag %b, expected %b", $time, lane.quad, quad);
                stop_with_failure("Transfer mode mismatch");
            end
            // Only bit 1 may carry data in a single-bit transfer
            if (!quad && (lane.nibble & 4'b1101) !== 4'b0000) begin
                $display("error: time %0t single-bit nibble %b, expected 00%b0",
                         $time, lane.nibble, lane.nibble[1]);
                stop_with_failure("Single-bit transfer drove lines other than bit 1");
            end
            got = quad ? {got[3:0], lane.nibble} : {got[6:0], lane.nibble[1]};
        end
        if (got !== exp) begin
            $display("error: time %0t reply byte %02h, expected %02h", $time, got, exp);
            stop_with_failure("Reply byte mismatch");
        end
    endtask

    task automatic run_read_id(input int bytes);
        send_host_byte(8'h9F);
        for (int k = 0; k < bytes; k++) begin
            receive_and_check(1'b0, chip_id[k % 3], 2);
        end
    endtask

    task automatic run_quad_read(input int bytes, input int max_delay);
        qspi_data_pkg::flash_addr_t base;
        qspi_data_pkg::flash_addr_t a;
        base = 24'($urandom());
        send_host_byte(8'hEB);
        send_host_byte(base[23:16]);
        send_host_byte(base[15:8]);
        send_host_byte(base[7:0]);
        send_host_byte(8'($urandom()));
        send_host_byte(8'h00);
        send_host_byte(8'h00);
        for (int k = 0; k < bytes; k++) begin
            a = base + 24'(k);
            receive_and_check(1'b1, a[23:16] ^ a[15:8] ^ a[7:0], max_delay);
        end
    endtask

    initial begin
        void'($urandom(32'h75d3_c49e));
        cs = 1'b1;
        host_req = 1'b0;
        host_lane = '0;
        out_ack = 1'b0;

        apply_reset();
        run_read_id(7);

        apply_reset();
        run_quad_read(12, 2);

        // Slow receiver lets the FIFO fill and stall the decoder
        apply_reset();
        run_quad_read(24, 30);

        apply_reset();
        send_host_byte(8'h03);
        repeat (60) begin
            @(negedge recv_got_byte);
            if (out_req) stop_with_failure("Unknown command produced an output transfer");
        end
        apply_reset();
        run_read_id(3);

        $display("All tests passed");
        $finish;
    end

endmodule

// File: qspi_pattern_flash.f
+incdir+.
qspi_cmd_pkg.sv
qspi_data_pkg.sv
qspi_command_decoder.sv
qspi_reply_fifo.sv
qspi_nibble_serializer.sv
qspi_pattern_flash.sv
qspi_pattern_flash_assertions.sv
qspi_pattern_flash_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module qspi_pattern_flash_tb \
    -f qspi_pattern_flash.f \
    -o qspi_pattern_flash_sim

./obj_dir/qspi_pattern_flash_sim
